// ==== verification/du_trace.txt ====
# op    arguments                    expected
# LOAD  count, program bytes (hex)   PC  value, four bytes MSB first
# RB DM byte count, byte sum         RUN halt delay, STEP count halt delay pc
PC 00000000 00 00 00 00
PC 12345678 12 34 56 78
RB 128 1984
DM 128 5776
# Program load, then run to halt
LOAD 16 10 21 32 43 54 65 76 87 98 a9 ba cb dc ed fe 0f
RUN 12
# Dump commands accepted again after halt
PC 8badf00d 8b ad f0 0d
DM 128 5776
# Second load with different bytes, then step mode
LOAD 16 ff 00 ee 11 dd 22 cc 33 bb 44 aa 55 99 66 88 77
STEP 3 6 00000044
RB 128 1984
PC cafe0123 ca fe 01 23
# Short run
LOAD 16 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
RUN 3
# Single step then continue
LOAD 16 80 40 20 10 08 04 02 01 fe fd fb f7 ef df bf 7f
STEP 1 4 deadbeef
PC 00000001 00 00 00 01
# Long run after a reload
LOAD 16 5a a5 5a a5 3c c3 3c c3 00 00 ff ff 12 34 56 78
RUN 40
RB 128 1984
DM 128 5776
# Many steps
LOAD 16 0c 1c 2c 3c 4c 5c 6c 7c 8c 9c ac bc cc dc ec fc
STEP 4 2 00001000
PC ffffffff ff ff ff ff

// ==== build.f ====
hw/du_pkg.sv
hw/du_command_fsm.sv
hw/du_program_loader.sv
hw/du_dump_serializer.sv
hw/debug_unit.sv
verification/du_datapath_model.sv
verification/tb_debug_unit.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f build.f --top-module tb_debug_unit -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/Vtb_debug_unit)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

// ==== verification/tb_debug_unit.sv ====
module tb_debug_unit;
    timeunit 1ns;
    timeprecision 100ps;

    logic                       i_clock;
    logic                       i_reset;
    logic                       i_rx_done;
    logic [du_pkg::NB_DATA-1:0] i_rx_data;
    logic                       i_tx_done;
    logic                       i_halt;
    logic [du_pkg::NB_WORD-1:0] i_pc_value;
    logic [du_pkg::NB_WORD-1:0] i_rb_data;
    logic [du_pkg::NB_WORD-1:0] i_dm_data;
    du_pkg::im_write_t          o_im_write;
    du_pkg::datapath_ctrl_t     o_datapath;
    du_pkg::dump_read_t         o_dump_read;
    logic [du_pkg::NB_DATA-1:0] o_tx_data;
    logic                       o_tx_start;

    logic [du_pkg::NB_WORD-1:0] pc_set;
    int                         halt_delay;
    int                         checks;
    int                         errors;
    int                         cycle_count;
    int                         cycle_limit;
    int                         step_pulses;
    logic [6:0]                 dump_controls; // Datapath controls seen during a dump
    logic [2:0]                 dump_reads;    // Read enables seen during a dump
    logic [du_pkg::NB_IM_ADDR-1:0] wr_addr_q[$];
    logic [du_pkg::NB_DATA-1:0]    wr_data_q[$];

    debug_unit debug_unit_i (.*);

    du_datapath_model datapath_model (
        .i_clock(i_clock), .i_reset(i_reset), .i_tx_start(o_tx_start),
        .i_tx_data(o_tx_data), .i_datapath(o_datapath), .i_dump_read(o_dump_read),
        .i_pc_value(pc_set), .i_halt_delay(halt_delay), .o_tx_done(i_tx_done),
        .o_halt(i_halt), .o_pc_value(i_pc_value), .o_rb_data(i_rb_data),
        .o_dm_data(i_dm_data)
    );

    initial begin
        i_clock = 1'b0;
        forever #2 i_clock = ~i_clock;
    end

    // Instruction memory writes and step pulses seen by the datapath
    always @(negedge i_clock) begin
        if (!i_reset) begin
            if (o_im_write.we) begin
                wr_addr_q.push_back(o_im_write.addr);
                wr_data_q.push_back(o_im_write.data);
            end
            if (o_datapath.step) step_pulses = step_pulses + 1;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic send_byte(input logic [7:0] value);
        i_rx_data = value;
        i_rx_done = 1'b1;
        @(posedge i_clock);
        #1;
        i_rx_done = 1'b0;
    endtask

    // Waits for n transmitter done pulses past the given base count
    task automatic wait_tx(input int done_base, input int n);
        dump_controls = '0;
        dump_reads    = '0;
        while (datapath_model.tx_done_count < done_base + n) begin
            @(negedge i_clock);
            dump_controls = dump_controls | o_datapath;
            dump_reads    = dump_reads | {o_dump_read.rb_read_enable,
                                          o_dump_read.dm_read_enable,
                                          o_dump_read.dm_du_flag};
        end
        repeat (3) @(posedge i_clock);
        #1;
    endtask

    function automatic logic [31:0] word_at(input int idx);
        return {datapath_model.tx_bytes[idx], datapath_model.tx_bytes[idx+1],
                datapath_model.tx_bytes[idx+2], datapath_model.tx_bytes[idx+3]};
    endfunction

    task automatic dump_pc(input string name, input logic [31:0] value,
                           input logic [31:0] expected, input logic [7:0] cmd);
        int base;
        int done_base;
        base      = datapath_model.tx_bytes.size();
        done_base = datapath_model.tx_done_count;
        pc_set    = value;
        if (cmd != 8'd0) send_byte(cmd);
        wait_tx(done_base, 4);
        check({name, " byte count"}, 4, datapath_model.tx_bytes.size() - base);
        check({name, " bytes"}, expected, word_at(base));
    endtask

    task automatic dump_bank(input string name, input logic [7:0] cmd, input int n,
                             input int sum, input logic [31:0] first,
                             input logic [31:0] last);
        int base;
        int done_base;
        int total;
        base      = datapath_model.tx_bytes.size();
        done_base = datapath_model.tx_done_count;
        total     = 0;
        send_byte(cmd);
        wait_tx(done_base, n);
        check({name, " byte count"}, n, datapath_model.tx_bytes.size() - base);
        for (int i = base; i < datapath_model.tx_bytes.size(); i++) begin
            total = total + int'(datapath_model.tx_bytes[i]);
        end
        check({name, " byte sum"}, sum, total);
        check({name, " first word"}, first, word_at(base));
        check({name, " last word"}, last, word_at(base + n - 4));
        check({name, " controls during dump"}, 0, 32'(dump_controls));
        check({name, " read enables"}, (cmd == du_pkg::CMD_DUMP_RB) ? 3'b100 : 3'b011,
              32'(dump_reads));
    endtask

    task automatic load_program(input int n, input logic [7:0] prog[256]);
        int wr_base;
        wr_base = wr_addr_q.size();
        send_byte(du_pkg::CMD_WRITE_IM);
        for (int i = 0; i < n; i++) begin
            send_byte(prog[i]);
            @(posedge i_clock); // Idle gap between bytes
            #1;
        end
        repeat (3) @(posedge i_clock);
        #1;
        check("LOAD write count", du_pkg::PROGRAM_BYTES, wr_addr_q.size() - wr_base);
        for (int i = 0; i < n && wr_base + i < wr_addr_q.size(); i++) begin
            check("LOAD address", i, 32'(wr_addr_q[wr_base + i]));
            check("LOAD data", prog[i], 32'(wr_data_q[wr_base + i]));
        end
    endtask

    task automatic wait_halt(input string name);
        @(negedge i_clock);
        while (!i_halt) begin
            @(negedge i_clock);
        end
        check({name, " enables at halt"}, 5'b11111, 32'(o_datapath[6:2]));
        repeat (2) @(posedge i_clock);
        #1;
        check({name, " controls after halt"}, 0, 32'(o_datapath));
    endtask

    task automatic run_program(input int delay);
        int writes;
        writes     = wr_addr_q.size();
        halt_delay = delay;
        send_byte(du_pkg::CMD_START);
        @(posedge i_clock); // A command taken as program data is written by now
        #1;
        check("RUN command not written", writes, wr_addr_q.size());
        check("RUN enables", 5'b11111, 32'(o_datapath[6:2]));
        check("RUN step flag", 0, 32'(o_datapath.step_flag));
        wait_halt("RUN");
    endtask

    task automatic step_program(input int count, input int delay, input logic [31:0] pc);
        int pulses;
        halt_delay = delay;
        pulses     = step_pulses;
        send_byte(du_pkg::CMD_STEP_MODE);
        @(posedge i_clock);
        #1;
        check("STEP flag", 1, 32'(o_datapath.step_flag));
        check("STEP pc enable", 1, 32'(o_datapath.pc_enable));
        for (int k = 0; k < count; k++) begin
            send_byte(du_pkg::CMD_STEP);
            check("STEP pulse high", 1, 32'(o_datapath.step));
            @(posedge i_clock);
            #1;
            check("STEP pulse low", 0, 32'(o_datapath.step));
            dump_pc("STEP pc dump", pc, pc, 8'd0);
            check("STEP flag after dump", 1, 32'(o_datapath.step_flag));
        end
        check("STEP pulse count", count, step_pulses - pulses);
        send_byte(du_pkg::CMD_CONTINUE);
        check("CONTINUE step flag", 0, 32'(o_datapath.step_flag));
        check("CONTINUE enables", 5'b11111, 32'(o_datapath[6:2]));
        wait_halt("CONTINUE");
    endtask

    initial begin
        int           fd;
        int           n;
        int           a;
        logic [63:0]  op;
        logic [31:0]  value;
        logic [31:0]  expected;
        logic [7:0]   b;
        logic [7:0]   prog[256];
        logic [8*200-1:0] line;

        i_reset     = 1'b1;
        i_rx_done   = 1'b0;
        i_rx_data   = '0;
        pc_set      = '0;
        halt_delay  = 1000;
        checks      = 0;
        errors      = 0;
        step_pulses = 0;
        cycle_limit = 2000;
        repeat (2) @(posedge i_clock);
        #1;
        i_reset = 1'b0;
        check("reset tx start", 0, 32'(o_tx_start));
        check("reset im write", 0, 32'(o_im_write));
        check("reset datapath", 0, 32'(o_datapath));
        check("reset dump read", 0, 32'(o_dump_read));

        fd = $fopen("verification/du_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file");
            errors = errors + 1;
        end else begin
            while ($fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    void'($fgets(line, fd));
                end else if (op == "LOAD") begin
                    void'($fscanf(fd, "%d", n));
                    for (int i = 0; i < n; i++) begin
                        void'($fscanf(fd, "%h", b));
                        prog[i] = b;
                    end
                    cycle_limit = cycle_limit + 40 * (n + 1);
                    load_program(n, prog);
                end else if (op == "PC") begin
                    void'($fscanf(fd, "%h", value));
                    expected = '0;
                    for (int i = 0; i < 4; i++) begin
                        void'($fscanf(fd, "%h", b));
                        expected = {expected[23:0], b};
                    end
                    cycle_limit = cycle_limit + 40 * 5;
                    dump_pc("PC dump", value, expected, du_pkg::CMD_DUMP_PC);
                    check("PC dump controls during dump", 0, 32'(dump_controls));
                    check("PC dump read enables", 0, 32'(dump_reads));
                end else if (op == "RB" || op == "DM") begin
                    void'($fscanf(fd, "%d %d", n, a));
                    cycle_limit = cycle_limit + 40 * (n + 1);
                    if (op == "RB") begin
                        dump_bank("RB dump", du_pkg::CMD_DUMP_RB, n, a, 32'h0,
                                  (du_pkg::RB_DEPTH - 1) * 32'h01010101);
                    end else begin
                        dump_bank("DM dump", du_pkg::CMD_DUMP_DM, n, a, 32'hA5000000,
                                  32'hA5000000 + du_pkg::DM_DEPTH - 1);
                    end
                end else if (op == "RUN") begin
                    void'($fscanf(fd, "%d", a));
                    cycle_limit = cycle_limit + 40 + a;
                    run_program(a);
                end else if (op == "STEP") begin
                    void'($fscanf(fd, "%d %d %h", n, a, value));
                    cycle_limit = cycle_limit + 40 * (2 + 5 * n) + a;
                    step_program(n, a, value);
                end else begin
                    $display("Unknown operation in the trace: %0s", op);
                    errors = errors + 1;
                end
            end
            $fclose(fd);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog whose limit grows as trace operations are read
    initial begin
        cycle_count = 0;
        do begin
            @(posedge i_clock);
            cycle_count = cycle_count + 1;
        end while (cycle_count < cycle_limit);
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== verification/du_datapath_model.sv ====
module du_datapath_model (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_tx_start,
    input  logic [du_pkg::NB_DATA-1:0] i_tx_data,
    input  du_pkg::datapath_ctrl_t     i_datapath,
    input  du_pkg::dump_read_t         i_dump_read,
    input  logic [du_pkg::NB_WORD-1:0] i_pc_value,
    input  int                         i_halt_delay,
    output logic                       o_tx_done,
    output logic                       o_halt,
    output logic [du_pkg::NB_WORD-1:0] o_pc_value,
    output logic [du_pkg::NB_WORD-1:0] o_rb_data,
    output logic [du_pkg::NB_WORD-1:0] o_dm_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [du_pkg::NB_DATA-1:0] tx_bytes[$]; // Every byte seen at a start pulse
    int                         tx_done_count;
    int                         tx_wait;
    int                         run_cycles;
    logic                       running;

    assign running    = i_datapath.pc_enable && !i_datapath.step_flag;
    assign o_pc_value = i_pc_value;

    // Read data only while the debug read port is enabled
    assign o_rb_data = i_dump_read.rb_read_enable ?
                       32'(i_dump_read.rb_addr) * 32'h01010101 : '1;
    assign o_dm_data = (i_dump_read.dm_read_enable && i_dump_read.dm_du_flag) ?
                       32'hA5000000 + 32'(i_dump_read.dm_addr) : '1;

    initial begin
        void'($urandom(32'h6969));
        o_tx_done     = 1'b0;
        o_halt        = 1'b0;
        tx_done_count = 0;
        tx_wait       = 0;
        run_cycles    = 0;
        forever begin
            @(posedge i_clock);
            #1;
            o_tx_done = 1'b0;
            if (i_reset) begin
                tx_wait    = 0;
                run_cycles = 0;
                o_halt     = 1'b0;
            end else begin
                if (i_tx_start) begin
                    tx_bytes.push_back(i_tx_data);
                    tx_wait = int'($urandom_range(6, 1)); // Transmitter busy time
                end else if (tx_wait > 0) begin
                    tx_wait = tx_wait - 1;
                    if (tx_wait == 0) begin
                        o_tx_done     = 1'b1;
                        tx_done_count = tx_done_count + 1;
                    end
                end
                if (running) run_cycles = run_cycles + 1;
                else run_cycles = 0;
                o_halt = running && (run_cycles >= i_halt_delay);
            end
        end
    end

endmodule

// ==== hw/debug_unit.sv ====
module debug_unit (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx_done,   // Byte ready from UART receiver
    input  logic [du_pkg::NB_DATA-1:0] i_rx_data,
    input  logic                       i_tx_done,   // Byte sent by UART transmitter
    input  logic                       i_halt,
    input  logic [du_pkg::NB_WORD-1:0] i_pc_value,
    input  logic [du_pkg::NB_WORD-1:0] i_rb_data,
    input  logic [du_pkg::NB_WORD-1:0] i_dm_data,
    output du_pkg::im_write_t          o_im_write,
    output du_pkg::datapath_ctrl_t     o_datapath,
    output du_pkg::dump_read_t         o_dump_read,
    output logic [du_pkg::NB_DATA-1:0] o_tx_data,
    output logic                       o_tx_start
);

    logic              load_active;
    logic              load_done;
    logic              dump_start;
    du_pkg::dump_src_e dump_src;
    logic              dump_done;

    du_command_fsm u_command_fsm (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_rx_done     (i_rx_done),
        .i_rx_data     (i_rx_data),
        .i_halt        (i_halt),
        .i_load_done   (load_done),
        .i_dump_done   (dump_done),
        .o_load_active (load_active),
        .o_dump_start  (dump_start),
        .o_dump_src    (dump_src),
        .o_datapath    (o_datapath)
    );

    // Program bytes share the receiver with commands
    du_program_loader u_program_loader (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_active    (load_active),
        .i_rx_done   (i_rx_done),
        .i_rx_data   (i_rx_data),
        .o_im_write  (o_im_write),
        .o_load_done (load_done)
    );

    du_dump_serializer u_dump_serializer (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_start     (dump_start),
        .i_src       (dump_src),
        .i_tx_done   (i_tx_done),
        .i_pc_value  (i_pc_value),
        .i_rb_data   (i_rb_data),
        .i_dm_data   (i_dm_data),
        .o_dump_read (o_dump_read),
        .o_tx_data   (o_tx_data),
        .o_tx_start  (o_tx_start),
        .o_done      (dump_done)
    );

endmodule

// ==== hw/du_dump_serializer.sv ====
module du_dump_serializer (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_start,
    input  du_pkg::dump_src_e          i_src,
    input  logic                       i_tx_done,
    input  logic [du_pkg::NB_WORD-1:0] i_pc_value,
    input  logic [du_pkg::NB_WORD-1:0] i_rb_data,
    input  logic [du_pkg::NB_WORD-1:0] i_dm_data,
    output du_pkg::dump_read_t         o_dump_read,
    output logic [du_pkg::NB_DATA-1:0] o_tx_data,
    output logic                       o_tx_start,
    output logic                       o_done
);

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_SETTLE, // Address out while read data settles
        SER_SEND,   // Start pulse cycle
        SER_WAIT
    } ser_state_e;

    ser_state_e                        seq;
    du_pkg::dump_src_e                 src;
    logic [du_pkg::NB_RB_ADDR-1:0]     word_count;
    logic [du_pkg::NB_BYTE_SEL-1:0]    byte_sel;   // 0 is the most significant byte
    logic [du_pkg::NB_WORD-1:0]        src_word;
    logic [du_pkg::NB_DATA-1:0]        tx_byte;
    logic                              busy;
    logic                              last_byte;
    logic                              last_word;

    assign busy = (seq != SER_IDLE);

    always_comb begin
        case (src)
            du_pkg::SRC_RB: src_word = i_rb_data;
            du_pkg::SRC_DM: src_word = i_dm_data;
            default:        src_word = i_pc_value;
        endcase
    end

    assign tx_byte = src_word[du_pkg::NB_WORD-1 - du_pkg::NB_DATA*int'(byte_sel) -: du_pkg::NB_DATA];

    assign last_byte = (int'(byte_sel) == du_pkg::BYTES_PER_WORD - 1);
    always_comb begin
        case (src)
            du_pkg::SRC_RB: last_word = (int'(word_count) == du_pkg::RB_DEPTH - 1);
            du_pkg::SRC_DM: last_word = (int'(word_count) == du_pkg::DM_DEPTH - 1);
            default:        last_word = 1'b1; // PC is a single word
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            seq        <= SER_IDLE;
            src        <= du_pkg::SRC_PC;
            word_count <= '0;
            byte_sel   <= '0;
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
        end else begin
            o_tx_start <= 1'b0;
            o_done     <= 1'b0;
            case (seq)
                SER_IDLE: begin
                    if (i_start) begin
                        src        <= i_src;
                        word_count <= '0;
                        byte_sel   <= '0;
                        seq        <= SER_SETTLE;
                    end
                end
                SER_SETTLE: begin
                    o_tx_start <= 1'b1;
                    seq        <= SER_SEND;
                end
                default: begin // SEND and WAIT both accept the done pulse
                    if (i_tx_done) begin
                        if (last_byte && last_word) begin
                            o_done <= 1'b1;
                            seq    <= SER_IDLE;
                        end else begin
                            if (last_byte) word_count <= word_count + 1'b1;
                            byte_sel <= byte_sel + 1'b1; // Wraps to 0 on a new word
                            seq      <= SER_SETTLE;
                        end
                    end else begin
                        seq <= SER_WAIT;
                    end
                end
            endcase
        end
    end

    // Byte held until the transmitter reports done
    always_ff @(posedge i_clock) begin
        if (seq == SER_SETTLE) o_tx_data <= tx_byte;
    end

    assign o_dump_read.rb_addr        = word_count;
    assign o_dump_read.rb_read_enable = busy && (src == du_pkg::SRC_RB);
    assign o_dump_read.dm_addr        = word_count[du_pkg::NB_DM_ADDR-1:0];
    assign o_dump_read.dm_read_enable = busy && (src == du_pkg::SRC_DM);
    assign o_dump_read.dm_du_flag     = busy && (src == du_pkg::SRC_DM);

endmodule

// ==== hw/du_program_loader.sv ====
module du_program_loader (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_active,
    input  logic                       i_rx_done,
    input  logic [du_pkg::NB_DATA-1:0] i_rx_data,
    output du_pkg::im_write_t          o_im_write,
    output logic                       o_load_done
);

    logic [du_pkg::NB_IM_ADDR-1:0] byte_count; // Index of the next program byte
    logic                          take_byte;
    logic                          last_byte;

    assign take_byte = i_active && i_rx_done;
    assign last_byte = (int'(byte_count) == du_pkg::PROGRAM_BYTES - 1);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_count  <= '0;
            o_im_write  <= '0;
            o_load_done <= 1'b0;
        end else begin
            o_im_write.we <= take_byte; // One-cycle write strobe
            o_load_done   <= take_byte && last_byte;
            if (take_byte) begin
                o_im_write.addr <= byte_count;
                o_im_write.data <= i_rx_data;
                // Wrap so the next load starts at address 0
                if (last_byte) begin
                    byte_count <= '0;
                end else begin
                    byte_count <= byte_count + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hw/du_command_fsm.sv ====
module du_command_fsm (
    input  logic                       i_clock,
    input  logic                       i_reset,
    input  logic                       i_rx_done,
    input  logic [du_pkg::NB_DATA-1:0] i_rx_data,
    input  logic                       i_halt,
    input  logic                       i_load_done,
    input  logic                       i_dump_done,
    output logic                       o_load_active,
    output logic                       o_dump_start,
    output du_pkg::dump_src_e          o_dump_src,
    output du_pkg::datapath_ctrl_t     o_datapath
);

    du_pkg::du_state_e      state;
    du_pkg::du_state_e      next_state;
    logic                   ret_step;      // Resume step mode after the dump
    logic                   next_ret_step;
    logic                   start_dump;
    du_pkg::dump_src_e      next_src;
    du_pkg::du_cmd_e        cmd;
    du_pkg::datapath_ctrl_t next_datapath;

    assign cmd = du_pkg::du_cmd_e'(i_rx_data);

    always_comb begin
        next_state    = state;
        next_ret_step = ret_step;
        next_src      = o_dump_src;
        start_dump    = 1'b0;
        case (state)
            du_pkg::IDLE: begin
                if (i_rx_done) begin
                    case (cmd)
                        du_pkg::CMD_WRITE_IM: next_state = du_pkg::LOAD;
                        du_pkg::CMD_DUMP_PC: begin
                            next_state = du_pkg::DUMP;
                            next_src   = du_pkg::SRC_PC;
                            start_dump = 1'b1;
                        end
                        du_pkg::CMD_DUMP_RB: begin
                            next_state = du_pkg::DUMP;
                            next_src   = du_pkg::SRC_RB;
                            start_dump = 1'b1;
                        end
                        du_pkg::CMD_DUMP_DM: begin
                            next_state = du_pkg::DUMP;
                            next_src   = du_pkg::SRC_DM;
                            start_dump = 1'b1;
                        end
                        default: ;
                    endcase
                    next_ret_step = 1'b0;
                end
            end
            du_pkg::LOAD: begin
                if (i_load_done) next_state = du_pkg::READY;
            end
            du_pkg::READY: begin
                if (i_rx_done) begin
                    case (cmd)
                        du_pkg::CMD_START:     next_state = du_pkg::RUN;
                        du_pkg::CMD_STEP_MODE: next_state = du_pkg::STEP_MODE;
                        default: ;
                    endcase
                end
            end
            du_pkg::RUN: begin
                if (i_halt) next_state = du_pkg::IDLE;
            end
            du_pkg::STEP_MODE: begin
                if (i_rx_done) begin
                    case (cmd)
                        du_pkg::CMD_STEP:     next_state = du_pkg::STEP_PULSE;
                        du_pkg::CMD_CONTINUE: next_state = du_pkg::RUN;
                        default: ;
                    endcase
                end
            end
            du_pkg::STEP_PULSE: begin // Lasts one cycle before the PC dump
                next_state    = du_pkg::DUMP;
                next_src      = du_pkg::SRC_PC;
                next_ret_step = 1'b1;
                start_dump    = 1'b1;
            end
            du_pkg::DUMP: begin
                if (i_dump_done) begin
                    next_state = ret_step ? du_pkg::STEP_MODE : du_pkg::IDLE;
                end
            end
            default: next_state = du_pkg::IDLE;
        endcase
    end

    // Controls decoded from the state being entered to line up with it
    always_comb begin
        next_datapath = '0;
        if (next_state == du_pkg::RUN || next_state == du_pkg::STEP_MODE ||
            next_state == du_pkg::STEP_PULSE ||
            (next_state == du_pkg::DUMP && next_ret_step)) begin
            next_datapath.im_enable = 1'b1;
            next_datapath.rb_enable = 1'b1;
            next_datapath.dm_enable = 1'b1;
            next_datapath.cu_enable = 1'b1;
            next_datapath.pc_enable = 1'b1;
        end
        // Post-step PC dump keeps the step flag so the datapath stays frozen
        if (next_state != du_pkg::RUN && next_datapath.pc_enable) begin
            next_datapath.step_flag = 1'b1;
        end
        next_datapath.step = (next_state == du_pkg::STEP_PULSE);
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state        <= du_pkg::IDLE;
            ret_step     <= 1'b0;
            o_dump_start <= 1'b0;
            o_dump_src   <= du_pkg::SRC_PC;
            o_datapath   <= '0;
        end else begin
            state        <= next_state;
            ret_step     <= next_ret_step;
            o_dump_start <= start_dump;
            o_dump_src   <= next_src;
            o_datapath   <= next_datapath;
        end
    end

    assign o_load_active = (state == du_pkg::LOAD);

endmodule

// ==== hw/du_pkg.sv ====
package du_pkg;

    // UART byte and processor word sizes
    localparam int NB_DATA        = 8;
    localparam int NB_WORD        = 32;
    localparam int BYTES_PER_WORD = 4;
    localparam int NB_BYTE_SEL    = 2;

    // Register bank and data memory geometry
    localparam int RB_DEPTH   = 32;
    localparam int NB_RB_ADDR = 5;
    localparam int DM_DEPTH   = 32;
    localparam int NB_DM_ADDR = 5;

    localparam int NB_IM_ADDR    = 8;
    localparam int PROGRAM_BYTES = 16; // Up to 256

    typedef enum logic [NB_DATA-1:0] {
        CMD_WRITE_IM  = 8'd1,
        CMD_START     = 8'd2,
        CMD_STEP_MODE = 8'd3,
        CMD_DUMP_RB   = 8'd4,
        CMD_DUMP_DM   = 8'd5,
        CMD_DUMP_PC   = 8'd6,
        CMD_STEP      = 8'd7,
        CMD_CONTINUE  = 8'd8
    } du_cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        READY,
        RUN,
        STEP_MODE,
        STEP_PULSE,
        DUMP
    } du_state_e;

    typedef enum logic [1:0] {
        SRC_PC,
        SRC_RB,
        SRC_DM
    } dump_src_e;

    typedef struct packed {
        logic                  we;
        logic [NB_IM_ADDR-1:0] addr;
        logic [NB_DATA-1:0]    data;
    } im_write_t;

    typedef struct packed {
        logic im_enable;
        logic rb_enable;
        logic dm_enable;
        logic cu_enable;
        logic pc_enable;
        logic step_flag; // Datapath advances only on step
        logic step;
    } datapath_ctrl_t;

    typedef struct packed {
        logic [NB_RB_ADDR-1:0] rb_addr;
        logic                  rb_read_enable;
        logic [NB_DM_ADDR-1:0] dm_addr;
        logic                  dm_read_enable;
        logic                  dm_du_flag; // DM address taken from debug unit
    } dump_read_t;

endpackage
